// File: core_decode.sv
// Decode stage: PC tracking, field decode and the decode register.
// One instruction per cycle at most, with no back-pressure.
// The PC loads boot_addr_i only while reset is asserted.
// Flush reloads the PC with TRAP_VECTOR and drops the sampled instruction.
`default_nettype none

module core_decode import mini_core_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               instr_valid_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  data_t              boot_addr_i,
  input  logic               flush_i,
  output logic               dec_valid_o,
  output data_t              dec_pc_o,
  output reg_addr_t          dec_rs1_o,
  output reg_addr_t          dec_rs2_o,
  output reg_addr_t          dec_rd_o,
  output alu_op_t            dec_alu_op_o,
  output logic               dec_use_imm_o,
  output data_t              dec_imm_o,
  output logic               dec_illegal_o
);

  data_t      pc_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i_type;
  data_t      imm_u_type;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  alu_op_t    alu_op;
  logic       use_imm;
  data_t      imm;
  logic       illegal;

  // funct3 to operation with funct7 = 0
  function automatic alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SRL:  return ALU_SRL;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  // --------------------
  // PC
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= boot_addr_i;
    end else if (flush_i) begin
      pc_q <= TRAP_VECTOR;
    end else if (instr_valid_i) begin
      pc_q <= pc_q + data_t'(4);
    end
  end

  // --------------------
  // Field decode
  // --------------------
  assign opcode     = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    imm     = imm_i_type;
    rs1     = instr_i[19:15];
    rs2     = instr_i[24:20];
    illegal = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u_type;
        rs1     = '0;
        rs2     = '0;
      end
      OPC_OP_IMM: begin
        alu_op  = base_op(funct3);
        use_imm = 1'b1;
        rs2     = '0;
        // Shift immediates reuse funct7 as an encoding field
        if (funct3 == F3_SLL) begin
          illegal = (funct7 != F7_BASE);
        end else if (funct3 == F3_SRL) begin
          if (funct7 == F7_ALT) begin
            alu_op = ALU_SRA;
          end else begin
            illegal = (funct7 != F7_BASE);
          end
        end
      end
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          alu_op = base_op(funct3);
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          alu_op = ALU_SUB;
        end else if (funct7 == F7_ALT && funct3 == F3_SRL) begin
          alu_op = ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // --------------------
  // Decode register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= instr_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      dec_pc_o      <= pc_q;
      dec_rs1_o     <= rs1;
      dec_rs2_o     <= rs2;
      dec_rd_o      <= instr_i[11:7];
      dec_alu_op_o  <= alu_op;
      dec_use_imm_o <= use_imm;
      dec_imm_o     <= imm;
      dec_illegal_o <= illegal;
    end
  end

endmodule

`default_nettype wire

// File: core_execute.sv
// Execute stage: operand select, ALU and the execute register.
// Forwards only from the instruction currently at commit; older results
// come from the register file, which has already been written by then.
// Shift amounts use the low 5 bits of the second operand.
`default_nettype none

module core_execute import mini_core_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,
  input  logic      dec_valid_i,
  input  data_t     dec_pc_i,
  input  reg_addr_t dec_rs1_i,
  input  reg_addr_t dec_rs2_i,
  input  reg_addr_t dec_rd_i,
  input  alu_op_t   dec_alu_op_i,
  input  logic      dec_use_imm_i,
  input  data_t     dec_imm_i,
  input  logic      dec_illegal_i,
  input  data_t     rs1_data_i,
  input  data_t     rs2_data_i,
  input  logic      fwd_valid_i,
  input  reg_addr_t fwd_rd_i,
  input  data_t     fwd_data_i,
  output reg_addr_t rf_rs1_o,
  output reg_addr_t rf_rs2_o,
  output logic      ex_valid_o,
  output data_t     ex_pc_o,
  output reg_addr_t ex_rd_o,
  output data_t     ex_wdata_o,
  output logic      ex_illegal_o
);

  logic       fwd_rs1;
  logic       fwd_rs2;
  data_t      op_a;
  data_t      op_b_reg;
  data_t      op_b;
  logic [4:0] shamt;
  data_t      alu_res;

  // --------------------
  // Operands
  // --------------------
  assign rf_rs1_o = dec_rs1_i;
  assign rf_rs2_o = dec_rs2_i;

  // x0 never forwards, whatever the older instruction targeted
  assign fwd_rs1 = fwd_valid_i && (fwd_rd_i != '0) && (fwd_rd_i == dec_rs1_i);
  assign fwd_rs2 = fwd_valid_i && (fwd_rd_i != '0) && (fwd_rd_i == dec_rs2_i);

  assign op_a     = fwd_rs1 ? fwd_data_i : rs1_data_i;
  assign op_b_reg = fwd_rs2 ? fwd_data_i : rs2_data_i;
  assign op_b     = dec_use_imm_i ? dec_imm_i : op_b_reg;
  assign shamt    = op_b[4:0];

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (dec_alu_op_i)
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = data_t'($signed(op_a) >>> shamt);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // --------------------
  // Execute register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      ex_pc_o      <= dec_pc_i;
      ex_rd_o      <= dec_rd_i;
      ex_illegal_o <= dec_illegal_i;
      // Excepting instructions report zero write data
      ex_wdata_o   <= dec_illegal_i ? '0 : alu_res;
    end
  end

endmodule

`default_nettype wire

// File: core_regfile.sv
// Integer register file, 31 writable registers plus a hardwired zero.
// Reads are combinational; a write lands on the next clock edge and is
// not bypassed to a read in the same cycle.
`default_nettype none

module core_regfile import mini_core_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  data_t     wdata_i,
  output data_t     rs1_data_o,
  output data_t     rs2_data_o
);

  // Register 0 has no storage
  data_t regs_q [NR_REGS-1:1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 always reads back as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// File: core_result.sv
// Result stage: commit reporting, register write and exception flush.
// Commit outputs are combinational from the execute register.
// The retired counter wraps at 2^32 and skips excepting instructions.
`default_nettype none

module core_result import mini_core_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               ex_valid_i,
  input  data_t              ex_pc_i,
  input  reg_addr_t          ex_rd_i,
  input  data_t              ex_wdata_i,
  input  logic               ex_illegal_i,
  output logic               flush_o,
  output logic               rf_we_o,
  output reg_addr_t          rf_waddr_o,
  output data_t              rf_wdata_o,
  output logic               fwd_valid_o,
  output logic               commit_valid_o,
  output data_t              commit_pc_o,
  output reg_addr_t          commit_rd_o,
  output data_t              commit_wdata_o,
  output logic               commit_exc_o,
  output logic [CAUSE_W-1:0] commit_cause_o,
  output data_t              instret_o
);

  logic  retire;
  data_t instret_q;

  // Only a clean commit updates architectural state
  assign retire = ex_valid_i & ~ex_illegal_i;

  // Exception at commit kills everything younger
  assign flush_o = ex_valid_i & ex_illegal_i;

  // Register write lands on the next edge
  assign rf_we_o     = retire && (ex_rd_i != '0);
  assign rf_waddr_o  = ex_rd_i;
  assign rf_wdata_o  = ex_wdata_i;
  assign fwd_valid_o = retire;

  // --------------------
  // Commit report
  // --------------------
  assign commit_valid_o = ex_valid_i;
  assign commit_pc_o    = ex_pc_i;
  assign commit_rd_o    = ex_rd_i;
  assign commit_wdata_o = ex_wdata_i;
  assign commit_exc_o   = flush_o;
  assign commit_cause_o = flush_o ? CAUSE_ILLEGAL : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instret_q <= '0;
    end else if (retire) begin
      instret_q <= instret_q + data_t'(1);
    end
  end

  assign instret_o = instret_q;

endmodule

`default_nettype wire

// File: mini_core.f
mini_core_pkg.sv
core_regfile.sv
core_decode.sv
core_execute.sv
core_result.sv
mini_core.sv
tb_mini_core.sv

// File: mini_core.sv
// Top level of the mini RV32 core: decode, execute, result, register file.
// Always accepts instr_valid_i; a commit appears two cycles after sampling.
// An illegal instruction kills the two younger instructions in flight.
`default_nettype none

module mini_core import mini_core_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               instr_valid_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  data_t              boot_addr_i,
  output logic               commit_valid_o,
  output data_t              commit_pc_o,
  output reg_addr_t          commit_rd_o,
  output data_t              commit_wdata_o,
  output logic               commit_exc_o,
  output logic [CAUSE_W-1:0] commit_cause_o,
  output data_t              instret_o
);

  // Decode to execute
  logic      dec_valid;
  data_t     dec_pc;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  alu_op_t   dec_alu_op;
  logic      dec_use_imm;
  data_t     dec_imm;
  logic      dec_illegal;

  // Execute to result
  logic      ex_valid;
  data_t     ex_pc;
  reg_addr_t ex_rd;
  data_t     ex_wdata;
  logic      ex_illegal;

  // Register file ports
  reg_addr_t rf_rs1;
  reg_addr_t rf_rs2;
  data_t     rs1_data;
  data_t     rs2_data;
  logic      rf_we;
  reg_addr_t rf_waddr;
  data_t     rf_wdata;

  // Commit feedback
  logic      flush;
  logic      fwd_valid;

  // --------------------
  // Decode
  // --------------------
  core_decode core_decode_i (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .boot_addr_i   ( boot_addr_i   ),
    .flush_i       ( flush         ),
    .dec_valid_o   ( dec_valid     ),
    .dec_pc_o      ( dec_pc        ),
    .dec_rs1_o     ( dec_rs1       ),
    .dec_rs2_o     ( dec_rs2       ),
    .dec_rd_o      ( dec_rd        ),
    .dec_alu_op_o  ( dec_alu_op    ),
    .dec_use_imm_o ( dec_use_imm   ),
    .dec_imm_o     ( dec_imm       ),
    .dec_illegal_o ( dec_illegal   )
  );

  // --------------------
  // Execute
  // --------------------
  core_execute core_execute_i (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .flush_i       ( flush       ),
    .dec_valid_i   ( dec_valid   ),
    .dec_pc_i      ( dec_pc      ),
    .dec_rs1_i     ( dec_rs1     ),
    .dec_rs2_i     ( dec_rs2     ),
    .dec_rd_i      ( dec_rd      ),
    .dec_alu_op_i  ( dec_alu_op  ),
    .dec_use_imm_i ( dec_use_imm ),
    .dec_imm_i     ( dec_imm     ),
    .dec_illegal_i ( dec_illegal ),
    .rs1_data_i    ( rs1_data    ),
    .rs2_data_i    ( rs2_data    ),
    // Forward from the instruction at commit
    .fwd_valid_i   ( fwd_valid   ),
    .fwd_rd_i      ( rf_waddr    ),
    .fwd_data_i    ( rf_wdata    ),
    .rf_rs1_o      ( rf_rs1      ),
    .rf_rs2_o      ( rf_rs2      ),
    .ex_valid_o    ( ex_valid    ),
    .ex_pc_o       ( ex_pc       ),
    .ex_rd_o       ( ex_rd       ),
    .ex_wdata_o    ( ex_wdata    ),
    .ex_illegal_o  ( ex_illegal  )
  );

  // --------------------
  // Result
  // --------------------
  core_result core_result_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .ex_valid_i     ( ex_valid       ),
    .ex_pc_i        ( ex_pc          ),
    .ex_rd_i        ( ex_rd          ),
    .ex_wdata_i     ( ex_wdata       ),
    .ex_illegal_i   ( ex_illegal     ),
    .flush_o        ( flush          ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .fwd_valid_o    ( fwd_valid      ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o ),
    .commit_exc_o   ( commit_exc_o   ),
    .commit_cause_o ( commit_cause_o ),
    .instret_o      ( instret_o      )
  );

  // --------------------
  // Register file
  // --------------------
  core_regfile core_regfile_i (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .rs1_i      ( rf_rs1   ),
    .rs2_i      ( rf_rs2   ),
    .we_i       ( rf_we    ),
    .waddr_i    ( rf_waddr ),
    .wdata_i    ( rf_wdata ),
    .rs1_data_o ( rs1_data ),
    .rs2_data_o ( rs2_data )
  );

endmodule

`default_nettype wire

// File: mini_core_pkg.sv
// Shared widths and encodings for the mini RV32 integer core.
// Only LUI and the integer register/immediate ALU ops are decoded.
// Every other encoding traps to TRAP_VECTOR with CAUSE_ILLEGAL.
`default_nettype none

package mini_core_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned INSTR_W    = 32;
  localparam int unsigned CAUSE_W    = 4;

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // --------------------
  // Trap handling
  // --------------------
  // Fixed handler address, no vectored mode
  localparam data_t TRAP_VECTOR = 32'h0000_0080;

  // Matches the RISC-V mcause code for an illegal instruction
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = 4'd2;

  // --------------------
  // Opcodes
  // --------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 values, ALT selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // --------------------
  // ALU operations
  // --------------------
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // Second operand straight through, for LUI
    ALU_PASS_B = 4'd10
  } alu_op_t;

endpackage

`default_nettype wire

// File: mini_core_vectors.txt
# last valid instr killed pc rd wdata exc cause (all hex)
# last=1 ends a group; random idle cycles may follow it
0 1 00500093 0 00001000 01 00000005 0 0
0 1 ffd08113 0 00001004 02 00000002 0 0
0 1 401101b3 0 00001008 03 fffffffd 0 0
0 1 4011d213 0 0000100c 04 fffffffe 0 0
0 1 01c1d293 0 00001010 05 0000000f 0 0
0 1 0011a333 0 00001014 06 00000001 0 0
0 1 0011b3b3 0 00001018 07 00000000 0 0
1 1 12345437 0 0000101c 08 12345000 0 0
0 1 0f044493 0 00001020 09 123450f0 0 0
0 1 0ff4f513 0 00001024 0a 000000f0 0 0
0 1 00f56593 0 00001028 0b 000000ff 0 0
0 1 00459613 0 0000102c 0c 00000ff0 0 0
0 1 00760013 0 00001030 00 00000ff7 0 0
0 1 00c006b3 0 00001034 0d 00000ff0 0 0
0 1 ffe1a713 0 00001038 0e 00000001 0 0
1 1 fff0b793 0 0000103c 0f 00000001 0 0
0 1 40f1d833 0 00001040 10 fffffffe 0 0
0 1 00f1d8b3 0 00001044 11 7ffffffe 0 0
0 1 00f61933 0 00001048 12 00001fe0 0 0
0 1 00c949b3 0 0000104c 13 00001010 0 0
0 1 0019ea33 0 00001050 14 00001015 0 0
0 1 013a7ab3 0 00001054 15 00001010 0 0
1 1 014a8b33 0 00001058 16 00002025 0 0
0 1 ffffffff 0 0000105c 1f 00000000 1 2
0 1 7ff00093 1 00000000 00 00000000 0 0
0 1 00100113 1 00000000 00 00000000 0 0
0 0 00000000 0 00000000 00 00000000 0 0
1 1 00208bb3 0 00000080 17 00000007 0 0
0 1 02208c33 0 00000084 18 00000000 1 2
0 1 00900b93 1 00000000 00 00000000 0 0
0 1 fffff0b7 1 00000000 00 00000000 0 0
1 1 001b8cb3 0 00000080 19 0000000c 0 0

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mini_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary -f mini_core.f --top-module tb_mini_core \
  -Mdir obj_dir -o tb_mini_core

./obj_dir/tb_mini_core | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tb_mini_core.sv
// Self-checking testbench for the mini RV32 core.
// Stimulus and expected commits come from mini_core_vectors.txt.
// Random idle gaps go only between vector groups, so kill slots stay intact.
// A commit must appear exactly 2 cycles after its sample edge.
`default_nettype none

module tb_mini_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam int          RST_CYCLES = 8;
  localparam int          MAX_GAP = 4;

  logic        clk_i;
  logic        arst_n_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] boot_addr_i;
  logic        commit_valid_o;
  logic [31:0] commit_pc_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_wdata_o;
  logic        commit_exc_o;
  logic [3:0]  commit_cause_o;
  logic [31:0] instret_o;

  // Vector table, one entry per data line
  logic        vec_last [$];
  logic        vec_valid [$];
  logic [31:0] vec_instr [$];
  logic        vec_killed [$];
  logic [31:0] vec_pc [$];
  logic [4:0]  vec_rd [$];
  logic [31:0] vec_wdata [$];
  logic        vec_exc [$];
  logic [3:0]  vec_cause [$];
  int          vec_gap [$];

  // Commits still to come, in program order
  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_wdata [$];
  logic        exp_exc [$];
  logic [3:0]  exp_cause [$];
  int          exp_cycle [$];
  int          exp_line [$];

  int cyc;
  int limit_ns;
  int commit_errs;
  int latency_errs;
  int tests_passed;
  int tests_failed;
  int exp_instret;

  mini_core mini_core_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o ),
    .commit_exc_o   ( commit_exc_o   ),
    .commit_cause_o ( commit_cause_o ),
    .instret_o      ( instret_o      )
  );

  // --------------------
  // Clock and cycle count
  // --------------------
  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s (%0d errors)", name, errs);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("mini_core_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open mini_core_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (n == 9) begin
            vec_last.push_back(f[0][0]);
            vec_valid.push_back(f[1][0]);
            vec_instr.push_back(f[2]);
            vec_killed.push_back(f[3][0]);
            vec_pc.push_back(f[4]);
            vec_rd.push_back(f[5][4:0]);
            vec_wdata.push_back(f[6]);
            vec_exc.push_back(f[7][0]);
            vec_cause.push_back(f[8][3:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // Commit monitor
  // --------------------
  always @(posedge clk_i) begin
    int line_no;
    if (arst_n_i && commit_valid_o) begin
      if (exp_pc.size() == 0) begin
        commit_errs++;
        $display("Unexpected commit at pc 0x%08h with no instruction pending", commit_pc_o);
      end else begin
        line_no = exp_line.pop_front();
        if (commit_pc_o !== exp_pc[0]) begin
          commit_errs++;
          $display("** Error: commit_pc_o = 0x%08h, expected 0x%08h (vector %0d)",
                   commit_pc_o, exp_pc[0], line_no);
        end
        if (commit_rd_o !== exp_rd[0]) begin
          commit_errs++;
          $display("** Error: commit_rd_o = 0x%02h, expected 0x%02h (vector %0d)",
                   commit_rd_o, exp_rd[0], line_no);
        end
        if (commit_wdata_o !== exp_wdata[0]) begin
          commit_errs++;
          $display("** Error: commit_wdata_o = 0x%08h, expected 0x%08h (vector %0d)",
                   commit_wdata_o, exp_wdata[0], line_no);
        end
        if (commit_exc_o !== exp_exc[0]) begin
          commit_errs++;
          $display("** Error: commit_exc_o = 0x%01h, expected 0x%01h (vector %0d)",
                   commit_exc_o, exp_exc[0], line_no);
        end
        if (exp_exc[0] && commit_cause_o !== exp_cause[0]) begin
          commit_errs++;
          $display("** Error: commit_cause_o = 0x%01h, expected 0x%01h (vector %0d)",
                   commit_cause_o, exp_cause[0], line_no);
        end
        if (cyc != exp_cycle[0] + 2) begin
          latency_errs++;
          $display("Commit of vector %0d came %0d cycles after its sample, not 2",
                   line_no, cyc - exp_cycle[0]);
        end
        void'(exp_pc.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_wdata.pop_front());
        void'(exp_exc.pop_front());
        void'(exp_cause.pop_front());
        void'(exp_cycle.pop_front());
      end
    end
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Watchdog timeout after %0d ns, %0d expected commits never arrived",
             limit_ns, exp_pc.size());
    $display("Some tests failed");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int gap_total;
    int reset_errs;
    int drain_errs;
    int instret_errs;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    boot_addr_i   = BOOT_ADDR;
    cyc           = 0;
    limit_ns      = 0;
    commit_errs   = 0;
    latency_errs  = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    exp_instret   = 0;
    gap_total     = 0;
    reset_errs    = 0;
    drain_errs    = 0;
    instret_errs  = 0;
    void'($urandom(32'h146bc63e));

    load_vectors();
    for (int i = 0; i < vec_valid.size(); i++) begin
      vec_gap.push_back(vec_last[i] ? int'($urandom_range(0, MAX_GAP)) : 0);
      gap_total += vec_gap[i];
      if (vec_valid[i] && !vec_killed[i] && !vec_exc[i]) begin
        exp_instret++;
      end
    end
    limit_ns = (vec_valid.size() + gap_total + 20) * 4;

    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Nothing commits and nothing retires before the first instruction
    repeat (2) begin
      @(posedge clk_i);
      if (commit_valid_o !== 1'b0 || instret_o !== 32'h0) begin
        reset_errs++;
        $display("** Error: commit_valid_o = 0x%01h, instret_o = 0x%08h, expected 0x0, 0x0",
                 commit_valid_o, instret_o);
      end
    end
    if (vec_pc.size() == 0 || vec_pc[0] !== BOOT_ADDR) begin
      reset_errs++;
      $display("First vector does not expect its commit at the boot address");
    end
    report_test("reset state", reset_errs);

    for (int i = 0; i < vec_valid.size(); i++) begin
      @(posedge clk_i);
      instr_valid_i <= vec_valid[i];
      instr_i       <= vec_instr[i];
      if (vec_valid[i] && !vec_killed[i]) begin
        exp_pc.push_back(vec_pc[i]);
        exp_rd.push_back(vec_rd[i]);
        exp_wdata.push_back(vec_wdata[i]);
        exp_exc.push_back(vec_exc[i]);
        exp_cause.push_back(vec_cause[i]);
        exp_cycle.push_back(cyc + 1);
        exp_line.push_back(i);
      end
      repeat (vec_gap[i]) begin
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b0;

    // Last commit is due 2 cycles after the final sample edge
    repeat (3) @(posedge clk_i);

    report_test("commit values", commit_errs);
    report_test("commit latency", latency_errs);
    if (exp_pc.size() != 0) begin
      drain_errs++;
      $display("%0d expected commits are still pending", exp_pc.size());
    end
    report_test("all commits seen", drain_errs);

    if (instret_o !== exp_instret) begin
      instret_errs++;
      $display("** Error: instret_o = 0x%08h, expected 0x%08h", instret_o, exp_instret);
    end
    report_test("retired count", instret_errs);

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
